/* hw/ip_rx_pkg.sv */
/*
 * IPv4 receive path definitions
 * protocol constants, header and stream structs, receive state encoding
 */
package ip_rx_pkg;

    // fixed IPv4 header without options
    localparam int             IP_HDR_BYTES   = 20;
    localparam logic [3:0]     IP_VERSION_V4  = 4'd4;
    localparam logic [3:0]     IP_IHL_MIN     = 4'd5;
    // one's-complement sum over a correct header
    localparam logic [15:0]    CSUM_GOOD      = 16'hffff;
    localparam logic [15:0]    ETHERTYPE_IPV4 = 16'h0800;

    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // field order matches the byte order on the wire
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } axis_byte_t;

    typedef struct packed {
        logic header_early_termination;
        logic payload_early_termination;
        logic invalid_header;
        logic invalid_checksum;
    } rx_error_t;

    typedef enum logic [1:0] {
        idle,
        read_header,
        read_payload,
        wait_last
    } rx_state_e;

endpackage

/* hw/ip_rx_fsm.sv */
/*
 * IPv4 receive FSM
 * steers header and payload handshakes, reports errors and busy
 */
`timescale 1ns/10ps

module ip_rx_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  s_eth_hdr_valid,
    output logic                  s_eth_hdr_ready,
    input  ip_rx_pkg::axis_byte_t s_payload,
    input  logic                  s_payload_valid,
    output logic                  s_payload_ready,
    input  logic                  m_hdr_ready,
    output logic                  m_hdr_valid,
    input  logic                  hdr_last,
    input  logic                  len_last,
    input  logic                  hdr_fields_ok,
    input  logic                  sum_ok,
    input  logic                  in_ready_early,
    output logic                  hdr_take,
    output logic                  hdr_byte_take,
    output logic                  pay_take,
    output ip_rx_pkg::axis_byte_t pay_out,
    output logic                  pay_out_valid,
    output logic                  busy,
    output ip_rx_pkg::rx_error_t  error
);
    import ip_rx_pkg::*;

    rx_state_e state_reg;
    rx_state_e state_next;
    logic      s_eth_hdr_ready_next;
    logic      s_payload_ready_next;
    logic      m_hdr_valid_next;
    rx_error_t error_next;
    logic      in_take;

    assign hdr_take      = s_eth_hdr_valid && s_eth_hdr_ready;
    assign in_take       = s_payload_valid && s_payload_ready;
    assign hdr_byte_take = in_take && (state_reg == read_header);
    assign pay_take      = in_take && (state_reg == read_payload);
    assign pay_out_valid = pay_take;

    // close the frame where the length runs out, flag a short one
    always_comb begin
        pay_out      = s_payload;
        pay_out.last = s_payload.last || len_last;
        pay_out.user = s_payload.user || (s_payload.last && !len_last);
    end

    always_comb begin
        state_next           = state_reg;
        s_eth_hdr_ready_next = 1'b0;
        s_payload_ready_next = 1'b0;
        m_hdr_valid_next     = m_hdr_valid && !m_hdr_ready;
        error_next           = '0;

        case (state_reg)
            idle: begin
                // new header only once the previous one is gone
                s_eth_hdr_ready_next = !m_hdr_valid_next;
                if (hdr_take) begin
                    s_eth_hdr_ready_next = 1'b0;
                    s_payload_ready_next = 1'b1;
                    state_next           = read_header;
                end
            end
            read_header: begin
                s_payload_ready_next = 1'b1;
                if (hdr_byte_take) begin
                    if (s_payload.last) begin
                        error_next.header_early_termination = 1'b1;
                        s_eth_hdr_ready_next = !m_hdr_valid_next;
                        s_payload_ready_next = 1'b0;
                        state_next           = idle;
                    end else if (hdr_last) begin
                        if (!hdr_fields_ok) begin
                            error_next.invalid_header = 1'b1;
                            state_next = wait_last;
                        end else if (!sum_ok) begin
                            error_next.invalid_checksum = 1'b1;
                            state_next = wait_last;
                        end else begin
                            m_hdr_valid_next     = 1'b1;
                            s_payload_ready_next = in_ready_early;
                            state_next           = read_payload;
                        end
                    end
                end
            end
            read_payload: begin
                s_payload_ready_next = in_ready_early;
                if (pay_take) begin
                    if (s_payload.last) begin
                        error_next.payload_early_termination = !len_last;
                        s_eth_hdr_ready_next = !m_hdr_valid_next;
                        s_payload_ready_next = 1'b0;
                        state_next           = idle;
                    end else if (len_last) begin
                        // padding follows, drop it
                        s_payload_ready_next = 1'b1;
                        state_next           = wait_last;
                    end
                end
            end
            wait_last: begin
                s_payload_ready_next = 1'b1;
                if (in_take && s_payload.last) begin
                    s_eth_hdr_ready_next = !m_hdr_valid_next;
                    s_payload_ready_next = 1'b0;
                    state_next           = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_reg       <= idle;
            s_eth_hdr_ready <= 1'b0;
            s_payload_ready <= 1'b0;
            m_hdr_valid     <= 1'b0;
            busy            <= 1'b0;
            error           <= '0;
        end else begin
            state_reg       <= state_next;
            s_eth_hdr_ready <= s_eth_hdr_ready_next;
            s_payload_ready <= s_payload_ready_next;
            m_hdr_valid     <= m_hdr_valid_next;
            busy            <= state_next != idle;
            error           <= error_next;
        end
    end

    // header and payload acceptance belong to different frame phases
    a_take_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(hdr_take && pay_take));

    // a new frame never overwrites a header still waiting at the output
    a_hdr_not_overwritten: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_take |-> !m_hdr_valid);

endmodule

/* hw/ip_rx_counter.sv */
/*
 * IPv4 receive counters
 * header byte index and remaining payload length
 */
`timescale 1ns/10ps

module ip_rx_counter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hdr_take,
    input  logic        hdr_byte_take,
    input  logic        pay_take,
    input  logic [15:0] ip_length,
    output logic [4:0]  hdr_idx,
    output logic        hdr_last,
    output logic        len_last
);
    import ip_rx_pkg::*;

    logic [15:0] remaining;

    assign hdr_last = hdr_idx == 5'(IP_HDR_BYTES - 1);
    // zero-length payload also ends on its first byte
    assign len_last = remaining <= 16'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_idx   <= '0;
            remaining <= '0;
        end else begin
            if (hdr_take || (hdr_byte_take && hdr_last)) begin
                hdr_idx <= '0;
            end else if (hdr_byte_take) begin
                hdr_idx <= hdr_idx + 5'd1;
            end
            // length field is complete well before the last header byte
            if (hdr_byte_take && hdr_last) begin
                remaining <= ip_length - 16'(IP_HDR_BYTES);
            end else if (pay_take) begin
                remaining <= remaining - 16'd1;
            end
        end
    end

    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_idx <= 5'(IP_HDR_BYTES - 1));

endmodule

/* hw/ip_hdr_capture.sv */
/*
 * IPv4 header capture
 * stores Ethernet and IP header fields and checks version, IHL and checksum
 */
`timescale 1ns/10ps

module ip_hdr_capture (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hdr_take,
    input  ip_rx_pkg::eth_hdr_t s_eth_hdr,
    input  logic                hdr_byte_take,
    input  logic [4:0]          hdr_idx,
    input  logic [7:0]          byte_in,
    output ip_rx_pkg::eth_hdr_t eth_hdr,
    output ip_rx_pkg::ip_hdr_t  ip_hdr,
    output logic                hdr_fields_ok,
    output logic                sum_ok
);
    import ip_rx_pkg::*;

    logic [8*IP_HDR_BYTES-1:0] hdr_bits;
    logic [15:0]               sum_reg;
    logic [15:0]               sum_next;
    logic [7:0]                ver_ihl;

    // 16-bit add with end-around carry
    function automatic logic [15:0] add_1c(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] t;
        t = a + b;
        return t[15:0] + 16'(t[16]);
    endfunction

    assign ip_hdr = ip_hdr_t'(hdr_bits);

    // even bytes are the upper half of a 16-bit word
    assign sum_next = add_1c(sum_reg, hdr_idx[0] ? {8'h00, byte_in} : {byte_in, 8'h00});
    assign sum_ok   = sum_next == CSUM_GOOD;

    assign ver_ihl = (hdr_idx == 5'd0) ? byte_in : hdr_bits[8*IP_HDR_BYTES-1 -: 8];
    assign hdr_fields_ok = (ver_ihl[7:4] == IP_VERSION_V4) && (ver_ihl[3:0] == IP_IHL_MIN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_reg <= '0;
        end else if (hdr_take) begin
            sum_reg <= '0;
        end else if (hdr_byte_take) begin
            sum_reg <= sum_next;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_take) begin
            eth_hdr <= s_eth_hdr;
        end
        // big-endian, byte 0 lands in the top bits
        if (hdr_byte_take) begin
            hdr_bits[8*(IP_HDR_BYTES - 1 - hdr_idx) +: 8] <= byte_in;
        end
    end

endmodule

/* hw/payload_skid_buffer.sv */
/*
 * Payload skid buffer
 * registered byte-stream output with one spare entry for stalls
 */
`timescale 1ns/10ps

module payload_skid_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ip_rx_pkg::axis_byte_t in_byte,
    input  logic                  in_valid,
    output logic                  in_ready_early,
    output ip_rx_pkg::axis_byte_t out_byte,
    output logic                  out_valid,
    input  logic                  out_ready
);
    import ip_rx_pkg::*;

    axis_byte_t temp_byte;
    logic       temp_valid;
    logic       in_ready_reg;
    logic       out_valid_next;
    logic       temp_valid_next;
    logic       in_to_out;
    logic       in_to_temp;
    logic       temp_to_out;

    // room next cycle if the sink drains or nothing is held
    assign in_ready_early = out_ready || (!temp_valid && !out_valid);

    always_comb begin
        out_valid_next  = out_valid;
        temp_valid_next = temp_valid;
        in_to_out       = 1'b0;
        in_to_temp      = 1'b0;
        temp_to_out     = 1'b0;
        if (in_ready_reg) begin
            if (out_ready || !out_valid) begin
                out_valid_next = in_valid;
                in_to_out      = 1'b1;
            end else begin
                // sink stalled, park the byte
                temp_valid_next = in_valid;
                in_to_temp      = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next  = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ready_reg <= 1'b0;
            out_valid    <= 1'b0;
            temp_valid   <= 1'b0;
        end else begin
            in_ready_reg <= in_ready_early;
            out_valid    <= out_valid_next;
            temp_valid   <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_byte <= in_byte;
        end else if (temp_to_out) begin
            out_byte <= temp_byte;
        end
        if (in_to_temp) begin
            temp_byte <= in_byte;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_byte));

endmodule

/* hw/ip_eth_rx.sv */
/*
 * IPv4 receiver top level
 * Ethernet frame in, IPv4 header fields and trimmed payload out
 */
`timescale 1ns/10ps

module ip_eth_rx (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  s_eth_hdr_valid,
    output logic                  s_eth_hdr_ready,
    input  ip_rx_pkg::eth_hdr_t   s_eth_hdr,
    input  ip_rx_pkg::axis_byte_t s_payload,
    input  logic                  s_payload_valid,
    output logic                  s_payload_ready,
    output logic                  m_hdr_valid,
    input  logic                  m_hdr_ready,
    output ip_rx_pkg::eth_hdr_t   m_eth_hdr,
    output ip_rx_pkg::ip_hdr_t    m_ip_hdr,
    output ip_rx_pkg::axis_byte_t m_payload,
    output logic                  m_payload_valid,
    input  logic                  m_payload_ready,
    output logic                  busy,
    output ip_rx_pkg::rx_error_t  error
);
    import ip_rx_pkg::*;

    logic       hdr_take;
    logic       hdr_byte_take;
    logic       pay_take;
    axis_byte_t pay_out;
    logic       pay_out_valid;
    logic [4:0] hdr_idx;
    logic       hdr_last;
    logic       len_last;
    logic       hdr_fields_ok;
    logic       sum_ok;
    logic       in_ready_early;

    ip_rx_fsm u_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .s_eth_hdr_valid (s_eth_hdr_valid),
        .s_eth_hdr_ready (s_eth_hdr_ready),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .m_hdr_ready     (m_hdr_ready),
        .m_hdr_valid     (m_hdr_valid),
        .hdr_last        (hdr_last),
        .len_last        (len_last),
        .hdr_fields_ok   (hdr_fields_ok),
        .sum_ok          (sum_ok),
        .in_ready_early  (in_ready_early),
        .hdr_take        (hdr_take),
        .hdr_byte_take   (hdr_byte_take),
        .pay_take        (pay_take),
        .pay_out         (pay_out),
        .pay_out_valid   (pay_out_valid),
        .busy            (busy),
        .error           (error)
    );

    ip_rx_counter u_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .hdr_take      (hdr_take),
        .hdr_byte_take (hdr_byte_take),
        .pay_take      (pay_take),
        .ip_length     (m_ip_hdr.length),
        .hdr_idx       (hdr_idx),
        .hdr_last      (hdr_last),
        .len_last      (len_last)
    );

    ip_hdr_capture u_capture (
        .clk           (clk),
        .rst_n         (rst_n),
        .hdr_take      (hdr_take),
        .s_eth_hdr     (s_eth_hdr),
        .hdr_byte_take (hdr_byte_take),
        .hdr_idx       (hdr_idx),
        .byte_in       (s_payload.data),
        .eth_hdr       (m_eth_hdr),
        .ip_hdr        (m_ip_hdr),
        .hdr_fields_ok (hdr_fields_ok),
        .sum_ok        (sum_ok)
    );

    payload_skid_buffer u_skid (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_byte        (pay_out),
        .in_valid       (pay_out_valid),
        .in_ready_early (in_ready_early),
        .out_byte       (m_payload),
        .out_valid      (m_payload_valid),
        .out_ready      (m_payload_ready)
    );

endmodule

/* tests/tb_ip_eth_rx.sv */
/*
 * IPv4 receiver testbench
 * drives frames from the pattern file, models the expected outputs and checks them
 */
`timescale 1ns/10ps

module tb_ip_eth_rx;
    import ip_rx_pkg::*;

    localparam int CLK_PERIOD = 100;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       s_eth_hdr_valid;
    logic       s_eth_hdr_ready;
    eth_hdr_t   s_eth_hdr;
    axis_byte_t s_payload;
    logic       s_payload_valid;
    logic       s_payload_ready;
    logic       m_hdr_valid;
    logic       m_hdr_ready = 1'b0;
    eth_hdr_t   m_eth_hdr;
    ip_hdr_t    m_ip_hdr;
    axis_byte_t m_payload;
    logic       m_payload_valid;
    logic       m_payload_ready = 1'b0;
    logic       busy;
    rx_error_t  error;

    // frames as read from the file
    eth_hdr_t   frame_eth[$];
    ip_hdr_t    frame_ip[$];
    int         frame_sent[$];
    int         frame_fault[$];
    // expected DUT responses, in output order
    eth_hdr_t   want_eth[$];
    ip_hdr_t    want_ip[$];
    axis_byte_t want_bytes[$];
    rx_error_t  want_err[$];

    logic [31:0] rand_state = 32'd77;
    int          watch_cycles = 0;

    ip_eth_rx UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .s_eth_hdr_valid (s_eth_hdr_valid),
        .s_eth_hdr_ready (s_eth_hdr_ready),
        .s_eth_hdr       (s_eth_hdr),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_eth_hdr       (m_eth_hdr),
        .m_ip_hdr        (m_ip_hdr),
        .m_payload       (m_payload),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready),
        .busy            (busy),
        .error           (error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // standard IPv4 header checksum over ten 16-bit words
    function automatic logic [15:0] header_csum(input ip_hdr_t h);
        logic [159:0] bits;
        logic [31:0]  acc;
        h.header_checksum = 16'h0000;
        bits = h;
        acc = 32'd0;
        for (int j = 0; j < 10; j++) begin
            acc = acc + bits[159 - 16*j -: 16];
        end
        acc = acc[15:0] + acc[31:16];
        acc = acc[15:0] + acc[31:16];
        return ~acc[15:0];
    endfunction

    function automatic logic [7:0] payload_byte(input int f, input int i);
        return 8'(f * 29 + i * 7 + (i >> 4) + 8'h5a);
    endfunction

    task automatic abort_run(input string why);
        if (why.len() > 0) begin
            $display("%s", why);
        end
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_eth_hdr(input string name, input eth_hdr_t got, input eth_hdr_t want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, want);
            abort_run("");
        end
    endtask

    task automatic check_ip_hdr(input string name, input ip_hdr_t got, input ip_hdr_t want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, want);
            abort_run("");
        end
    endtask

    task automatic check_byte(input string name, input axis_byte_t got, input axis_byte_t want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, want);
            abort_run("");
        end
    endtask

    task automatic check_error(input string name, input rx_error_t got, input rx_error_t want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, want);
            abort_run("");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, want);
            abort_run("");
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_header(input eth_hdr_t eh);
        s_eth_hdr       = eh;
        s_eth_hdr_valid = 1'b1;
        while (!s_eth_hdr_ready) @(negedge clk);
        @(negedge clk);
        s_eth_hdr_valid = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] d, input logic last);
        s_payload.data  = d;
        s_payload.last  = last;
        s_payload.user  = 1'b0;
        s_payload_valid = 1'b1;
        while (!s_payload_ready) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic run_frame(input int f);
        eth_hdr_t     eh;
        ip_hdr_t      ih;
        logic [159:0] bits;
        axis_byte_t   b;
        rx_error_t    err;
        int           sent;
        int           fault;
        int           pay_len;
        int           keep;
        eh      = frame_eth[f];
        ih      = frame_ip[f];
        sent    = frame_sent[f];
        fault   = frame_fault[f];
        bits    = ih;
        pay_len = int'(ih.length) - IP_HDR_BYTES;
        err     = '0;
        if (fault == 3) begin
            err.header_early_termination = 1'b1;
        end else if (ih.version != IP_VERSION_V4 || ih.ihl != IP_IHL_MIN) begin
            err.invalid_header = 1'b1;
        end else if (fault == 1) begin
            err.invalid_checksum = 1'b1;
        end else begin
            want_eth.push_back(eh);
            want_ip.push_back(ih);
            // output stops at the IP length, or earlier on a short frame
            keep = (sent < pay_len) ? sent : pay_len;
            for (int i = 0; i < keep; i++) begin
                b.data = payload_byte(f, i);
                b.last = (i == keep - 1);
                b.user = (i == keep - 1) && (sent < pay_len);
                want_bytes.push_back(b);
            end
            err.payload_early_termination = (sent < pay_len);
        end
        if (err != '0) begin
            want_err.push_back(err);
        end

        send_header(eh);
        // a frame is in progress from its header transfer on
        check_bit("busy", busy, 1'b1);
        if (fault == 3) begin
            for (int i = 0; i < sent; i++) begin
                send_byte(bits[159 - 8*i -: 8], i == sent - 1);
            end
        end else begin
            for (int i = 0; i < IP_HDR_BYTES; i++) begin
                send_byte(bits[159 - 8*i -: 8], 1'b0);
            end
            for (int i = 0; i < sent; i++) begin
                send_byte(payload_byte(f, i), i == sent - 1);
            end
        end
        s_payload_valid = 1'b0;
        // every frame ends with its input last
        check_bit("busy", busy, 1'b0);
    endtask

    // output side: random ready, then check whatever transfers on the next edge
    always @(negedge clk) begin
        rand_state      = lcg_next(rand_state);
        m_hdr_ready     = rand_state[18:16] != 3'd0;
        m_payload_ready = rand_state[21:20] != 2'd0;
        if (rst_n) begin
            if (m_hdr_valid && m_hdr_ready) begin
                if (want_eth.size() == 0) begin
                    abort_run("header output appeared where no frame should pass");
                end else begin
                    check_eth_hdr("m_eth_hdr", m_eth_hdr, want_eth.pop_front());
                    check_ip_hdr("m_ip_hdr", m_ip_hdr, want_ip.pop_front());
                end
            end
            if (m_payload_valid && m_payload_ready) begin
                if (want_bytes.size() == 0) begin
                    abort_run("payload byte output where none was expected");
                end else begin
                    check_byte("m_payload", m_payload, want_bytes.pop_front());
                end
            end
            if (error != '0) begin
                if (want_err.size() == 0) begin
                    abort_run("error pulse seen where no error was expected");
                end else begin
                    check_error("error", error, want_err.pop_front());
                end
            end
        end
    end

    initial begin
        wait (watch_cycles > 0);
        #(watch_cycles * CLK_PERIOD);
        abort_run("timeout: the DUT did not finish all frames in time");
    end

    initial begin
        int          fd;
        int          n;
        int          total_bytes;
        string       line;
        logic [47:0] fld [0:16];
        eth_hdr_t    eh;
        ip_hdr_t     ih;
        rst_n           = 1'b0;
        s_eth_hdr_valid = 1'b0;
        s_eth_hdr       = '0;
        s_payload       = '0;
        s_payload_valid = 1'b0;
        total_bytes     = 0;

        fd = $fopen("tests/ip_rx_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the pattern file tests/ip_rx_patterns.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %d",
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                    fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                    fld[15], fld[16]);
                if (n != 17) begin
                    abort_run("malformed line in the pattern file");
                end
                eh.dest_mac          = fld[0];
                eh.src_mac           = fld[1];
                eh.eth_type          = fld[2][15:0];
                ih.version           = fld[3][3:0];
                ih.ihl               = fld[4][3:0];
                ih.dscp              = fld[5][5:0];
                ih.ecn               = fld[6][1:0];
                ih.length            = fld[7][15:0];
                ih.identification    = fld[8][15:0];
                ih.flags             = fld[9][2:0];
                ih.fragment_offset   = fld[10][12:0];
                ih.ttl               = fld[11][7:0];
                ih.protocol          = fld[12][7:0];
                ih.source_ip         = fld[13][31:0];
                ih.dest_ip           = fld[14][31:0];
                // a corrupted checksum never flips between the two zero forms
                ih.header_checksum   = header_csum(ih) ^ ((fld[16] == 1) ? 16'h0101 : 16'h0000);
                frame_eth.push_back(eh);
                frame_ip.push_back(ih);
                frame_sent.push_back(int'(fld[15]));
                frame_fault.push_back(int'(fld[16]));
                total_bytes += (fld[16] == 3) ? int'(fld[15]) : IP_HDR_BYTES + int'(fld[15]);
            end
        end
        $fclose(fd);
        if (frame_eth.size() == 0) begin
            abort_run("the pattern file holds no frames");
        end
        watch_cycles = (total_bytes + 40 * frame_eth.size()) * 4;

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int f = 0; f < frame_eth.size(); f++) begin
            run_frame(f);
        end

        // let the output side drain
        while (busy || m_hdr_valid || m_payload_valid) @(negedge clk);
        @(posedge clk);
        if (want_eth.size() == 0 && want_bytes.size() == 0 && want_err.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run("the DUT went idle with expected outputs or errors still missing");
        end
    end

endmodule

/* tests/ip_rx_patterns.txt */
# dest_mac src_mac eth_type ver ihl dscp ecn length ident flags frag ttl proto src_ip dst_ip sent fault
# hex except sent and fault; fault 0 none, 1 bad checksum, 2 bad version/IHL, 3 header cut
# sent is the payload byte count, or for fault 3 the header bytes sent before last
02005e0a0b01 001b21aa0001 0800 4 5 00 0 0032 1c46 2 0000 40 11 c0a80001 c0a800c7 30 0
02005e0a0b02 001b21aa0002 0800 4 5 2e 1 001e 0a01 0 0000 80 06 0a000001 0a0000fe 26 0
02005e0a0b03 001b21aa0003 0800 4 5 00 0 0028 beef 2 0000 40 11 c0a80102 c0a80103 20 1
02005e0a0b04 001b21aa0004 0800 4 5 0a 2 0040 1234 1 0abc 20 06 ac100001 ac100002 44 0
02005e0a0b05 001b21aa0005 0800 6 5 00 0 0030 5555 0 0000 40 11 c0a80001 c0a80002 28 2
02005e0a0b06 001b21aa0006 0800 4 6 00 0 002c 6666 2 0000 40 11 c0a80003 c0a80004 24 2
02005e0a0b07 001b21aa0007 0800 4 5 00 0 0040 7777 2 0000 40 11 c0a80005 c0a80006 9 3
02005e0a0b08 001b21aa0008 0800 4 5 00 3 0015 8888 2 0000 01 01 0a0a0a0a 0b0b0b0b 1 0
02005e0a0b09 001b21aa0009 0800 4 5 3f 0 0050 9999 0 1fff ff 11 c0a80009 c0a8000a 17 0
02005e0a0b0a 001b21aa000a 0800 4 5 00 0 0024 aaaa 2 0000 40 06 c0a8000b c0a8000c 40 0
02005e0a0b0b 001b21aa000b 0800 4 5 00 0 0030 bbbb 2 0000 40 11 c0a8000d c0a8000e 19 3
02005e0a0b0c 001b21aa000c 0800 4 5 12 1 0064 cccc 2 0000 40 11 c0a8000f c0a80010 80 0
ffffffffffff 001b21aa000d 0800 4 5 00 0 0020 dddd 0 0000 40 11 c0a80011 ffffffff 12 0

/* src.f */
hw/ip_rx_pkg.sv
hw/ip_rx_fsm.sv
hw/ip_rx_counter.sv
hw/ip_hdr_capture.sv
hw/payload_skid_buffer.sv
hw/ip_eth_rx.sv
tests/tb_ip_eth_rx.sv

/* Bender.yml */
package:
  name: ip_eth_rx

sources:
  - files:
      - hw/ip_rx_pkg.sv
      - hw/ip_rx_fsm.sv
      - hw/ip_rx_counter.sv
      - hw/ip_hdr_capture.sv
      - hw/payload_skid_buffer.sv
      - hw/ip_eth_rx.sv
  - target: test
    files:
      - tests/tb_ip_eth_rx.sv
